// File: Bender.yml
package:
  name: emac

sources:
  - files:
      - emac_pkg.sv
      - emac_apb_slave.sv
      - emac_cfg_regs.sv
      - emac_miim.sv
      - emac.sv
  - target: test
    files:
      - emac_properties.sv
      - emac_tb.sv

// File: compile.f
emac_pkg.sv
emac_apb_slave.sv
emac_cfg_regs.sv
emac_miim.sv
emac.sv
emac_properties.sv
emac_tb.sv

// File: emac.sv
// Ethernet MAC configuration top
// APB slave feeding the link configuration registers and the MDIO engine
`timescale 1ns/1ps
`default_nettype none

module emac
   import emac_pkg::*;
(
   input  logic      pclk,
   input  logic      presetn_sync,
   // APB
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_addr_t paddr,
   input  apb_data_t pwdata,
   output apb_data_t prdata,
   output logic      pready,
   output logic      pslverr,
   // Link configuration to the datapath
   output cfg_t      cfg,
   // MII management
   output logic      mdc,
   output logic      mdo,
   output logic      mdo_en,
   input  logic      mdi,
   output logic      irq
);

   reg_bus_t  bus;
   logic      cfg_sel;
   logic      miim_sel;
   apb_data_t cfg_rdata;
   apb_data_t miim_rdata;

   //==========================================================
   // APB front end
   //==========================================================
   emac_apb_slave u_apb
   (
      .pclk         ( pclk         ),
      .presetn_sync ( presetn_sync ),
      .psel         ( psel         ),
      .penable      ( penable      ),
      .pwrite       ( pwrite       ),
      .paddr        ( paddr        ),
      .pwdata       ( pwdata       ),
      .prdata       ( prdata       ),
      .pready       ( pready       ),
      .pslverr      ( pslverr      ),
      .bus          ( bus          ),
      .cfg_sel      ( cfg_sel      ),
      .miim_sel     ( miim_sel     ),
      .cfg_rdata    ( cfg_rdata    ),
      .miim_rdata   ( miim_rdata   )
   );

   // Link mode and station address
   emac_cfg_regs u_cfg
   (
      .pclk         ( pclk         ),
      .presetn_sync ( presetn_sync ),
      .sel          ( cfg_sel      ),
      .bus          ( bus          ),
      .rdata        ( cfg_rdata    ),
      .cfg          ( cfg          )
   );

   // MDIO frames
   emac_miim u_miim
   (
      .pclk         ( pclk         ),
      .presetn_sync ( presetn_sync ),
      .sel          ( miim_sel     ),
      .bus          ( bus          ),
      .mdi          ( mdi          ),
      .rdata        ( miim_rdata   ),
      .mdc          ( mdc          ),
      .mdo          ( mdo          ),
      .mdo_en       ( mdo_en       ),
      .irq          ( irq          )
   );

endmodule

`default_nettype wire

// File: emac_apb_slave.sv
// APB slave of the Ethernet MAC register block
// Zero wait states; decodes the cfg and MIIM groups, muxes read data
// and flags unmapped or misaligned accesses with pslverr
`timescale 1ns/1ps
`default_nettype none

module emac_apb_slave
   import emac_pkg::*;
(
   input  logic      pclk,
   input  logic      presetn_sync,
   // APB
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_addr_t paddr,
   input  apb_data_t pwdata,
   output apb_data_t prdata,
   output logic      pready,
   output logic      pslverr,
   // Register groups
   output reg_bus_t  bus,
   output logic      cfg_sel,
   output logic      miim_sel,
   input  apb_data_t cfg_rdata,
   input  apb_data_t miim_rdata
);

   logic     access_q;
   logic     access;
   logic     cfg_hit;
   logic     miim_hit;
   logic     mapped;
   reg_ofs_t ofs;

   //==========================================================
   // Phase tracking
   //==========================================================
   // Set by the setup phase, so access is true for one cycle only
   always_ff @(posedge pclk or negedge presetn_sync)
   begin
      if (!presetn_sync)
         access_q <= 1'b0;
      else
         access_q <= psel & ~penable;
   end

   assign access = psel & penable & access_q;

   //==========================================================
   // Address decode
   //==========================================================
   assign ofs      = paddr[GRP_LSB-1:OFS_LSB];
   assign cfg_sel  = (paddr[ADDR_W-1:GRP_LSB] == GRP_CFG);
   assign miim_sel = (paddr[ADDR_W-1:GRP_LSB] == GRP_MIIM);

   // Unused offsets inside a group count as unmapped
   assign cfg_hit  = cfg_sel & (ofs inside {OFS_MAC_LO, OFS_MAC_HI, OFS_MODE});
   assign miim_hit = miim_sel & (ofs inside {OFS_MCR, OFS_MDR});
   assign mapped   = (paddr[OFS_LSB-1:0] == '0) & (cfg_hit | miim_hit);

   // Strobes only for mapped registers
   always_comb
   begin
      bus.offset = ofs;
      bus.wr     = access & pwrite & mapped;
      bus.rd     = access & ~pwrite & mapped;
      bus.wdata  = pwdata;
   end

   //==========================================================
   // Response
   //==========================================================
   assign pready  = 1'b1;
   assign pslverr = access & ~mapped;

   // Zero outside a mapped read
   always_comb
   begin
      if (bus.rd)
         prdata = cfg_sel ? cfg_rdata : miim_rdata;
      else
         prdata = '0;
   end

endmodule

`default_nettype wire

// File: emac_cfg_regs.sv
// Ethernet MAC configuration registers
// Station address and link mode, exported as one struct to the datapath
`timescale 1ns/1ps
`default_nettype none

module emac_cfg_regs
   import emac_pkg::*;
(
   input  logic      pclk,
   input  logic      presetn_sync,
   input  logic      sel,
   input  reg_bus_t  bus,
   output apb_data_t rdata,
   output cfg_t      cfg
);

   //==========================================================
   // Register writes
   //==========================================================
   always_ff @(posedge pclk or negedge presetn_sync)
   begin
      if (!presetn_sync)
      begin
         cfg <= '{mac_addr: DEFAULT_MAC,
                  speed:    '0,
                  duplex:   1'b0,
                  ifg:      DEFAULT_IFG};
      end
      else if (sel && bus.wr)
      begin
         case (bus.offset)
            // Low word of the MAC address
            OFS_MAC_LO:
               cfg.mac_addr[DATA_W-1:0] <= bus.wdata;
            // Upper 16 bits sit in the low half
            OFS_MAC_HI:
               cfg.mac_addr[MAC_W-1:DATA_W] <= bus.wdata[MAC_W-DATA_W-1:0];
            OFS_MODE:
            begin
               cfg.speed  <= bus.wdata[MODE_SPEED_LSB +: $bits(speed_t)];
               cfg.duplex <= bus.wdata[MODE_DUPLEX_BIT];
               cfg.ifg    <= bus.wdata[MODE_IFG_LSB +: IFG_W];
            end
            default:
               ;
         endcase
      end
   end

   //==========================================================
   // Read-back
   //==========================================================
   // Fields in their register positions, rest zero
   always_comb
   begin
      rdata = '0;
      case (bus.offset)
         OFS_MAC_LO:
            rdata = cfg.mac_addr[DATA_W-1:0];
         OFS_MAC_HI:
            rdata[MAC_W-DATA_W-1:0] = cfg.mac_addr[MAC_W-1:DATA_W];
         OFS_MODE:
         begin
            rdata[MODE_SPEED_LSB +: $bits(speed_t)] = cfg.speed;
            rdata[MODE_DUPLEX_BIT]                  = cfg.duplex;
            rdata[MODE_IFG_LSB +: IFG_W]            = cfg.ifg;
         end
         default:
            rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: emac_miim.sv
// MII management engine (IEEE 802.3 clause 22)
// Control and data registers, mdc divider and a 64-bit frame shifter;
// one frame per control write, irq level on completion
`timescale 1ns/1ps
`default_nettype none

module emac_miim
   import emac_pkg::*;
(
   input  logic      pclk,
   input  logic      presetn_sync,
   input  logic      sel,
   input  reg_bus_t  bus,
   input  logic      mdi,
   output apb_data_t rdata,
   output logic      mdc,
   output logic      mdo,
   output logic      mdo_en,
   output logic      irq
);

   miim_state_t           state;
   phy_addr_t             phy_addr;
   phy_addr_t             reg_addr;
   logic                  rd_op;
   mdc_div_t              div;
   mdc_div_t              div_cnt;
   logic                  mdc_q;
   logic [5:0]            bit_cnt;
   logic [FRAME_BITS-1:0] shift;
   logic [FRAME_BITS-1:0] frame;
   mdio_data_t            mdr;
   logic                  busy;
   logic                  done;
   logic                  mcr_wr;
   logic                  mdr_wr;
   logic                  start;
   logic                  tick;
   logic                  mdc_rise;
   logic                  mdc_fall;
   logic                  data_phase;

   //==========================================================
   // Register strobes and status
   //==========================================================
   assign mcr_wr = sel & bus.wr & (bus.offset == OFS_MCR);
   assign mdr_wr = sel & bus.wr & (bus.offset == OFS_MDR);
   assign busy   = (state == MIIM_SHIFT);
   assign done   = (state == MIIM_DONE);
   // Writes while busy are dropped
   assign start  = mcr_wr & ~busy;

   // Half-period tick of mdc
   assign tick     = busy & (div_cnt == div);
   assign mdc_rise = tick & ~mdc_q;
   assign mdc_fall = tick & mdc_q;
   // Last 16 bits carry the PHY data on a read
   assign data_phase = (bit_cnt >= 6'(HDR_BITS + 2));

   // Frame image from the command being written
   always_comb
   begin
      if (bus.wdata[MCR_READ_BIT])
         frame = {{PREAMBLE_BITS{1'b1}}, 2'b01, 2'b10,
                  bus.wdata[MCR_PHY_LSB +: $bits(phy_addr_t)],
                  bus.wdata[MCR_REG_LSB +: $bits(phy_addr_t)],
                  2'b11, 16'hffff};
      else
         frame = {{PREAMBLE_BITS{1'b1}}, 2'b01, 2'b01,
                  bus.wdata[MCR_PHY_LSB +: $bits(phy_addr_t)],
                  bus.wdata[MCR_REG_LSB +: $bits(phy_addr_t)],
                  2'b10, mdr};
   end

   //==========================================================
   // Frame FSM and mdc divider
   //==========================================================
   always_ff @(posedge pclk or negedge presetn_sync)
   begin
      if (!presetn_sync)
      begin
         state    <= MIIM_IDLE;
         phy_addr <= '0;
         reg_addr <= '0;
         rd_op    <= 1'b0;
         div      <= DEFAULT_DIV;
         div_cnt  <= '0;
         mdc_q    <= 1'b0;
         bit_cnt  <= '0;
      end
      else
      begin
         case (state)
            MIIM_IDLE, MIIM_DONE:
            begin
               // Leaving DONE clears the irq level
               if (start)
               begin
                  state    <= MIIM_SHIFT;
                  phy_addr <= bus.wdata[MCR_PHY_LSB +: $bits(phy_addr_t)];
                  reg_addr <= bus.wdata[MCR_REG_LSB +: $bits(phy_addr_t)];
                  rd_op    <= bus.wdata[MCR_READ_BIT];
                  div      <= bus.wdata[MCR_DIV_LSB +: DIV_W];
                  div_cnt  <= '0;
                  mdc_q    <= 1'b0;
                  bit_cnt  <= '0;
               end
            end
            MIIM_SHIFT:
            begin
               if (tick)
               begin
                  div_cnt <= '0;
                  mdc_q   <= ~mdc_q;
                  // Falling edge closes a bit period
                  if (mdc_q)
                  begin
                     bit_cnt <= bit_cnt + 6'd1;
                     if (bit_cnt == 6'(FRAME_BITS - 1))
                        state <= MIIM_DONE;
                  end
               end
               else
                  div_cnt <= div_cnt + 1'b1;
            end
            default:
               state <= MIIM_IDLE;
         endcase
      end
   end

   // Next bit presented after each falling edge
   always_ff @(posedge pclk)
   begin
      if (start)
         shift <= frame;
      else if (mdc_fall)
         shift <= {shift[FRAME_BITS-2:0], 1'b1};
   end

   // Data register: software write or mdi sampled on rising mdc
   always_ff @(posedge pclk or negedge presetn_sync)
   begin
      if (!presetn_sync)
         mdr <= '0;
      else if (mdr_wr && !busy)
         mdr <= bus.wdata[$bits(mdio_data_t)-1:0];
      else if (mdc_rise && rd_op && data_phase)
         mdr <= {mdr[$bits(mdio_data_t)-2:0], mdi};
   end

   //==========================================================
   // Outputs
   //==========================================================
   assign mdc    = mdc_q;
   assign mdo    = busy ? shift[FRAME_BITS-1] : 1'b1;
   // Bus released for turnaround and data of a read
   assign mdo_en = busy & (~rd_op | (bit_cnt < 6'(HDR_BITS)));
   assign irq    = done;

   always_comb
   begin
      rdata = '0;
      case (bus.offset)
         OFS_MCR:
         begin
            rdata[MCR_PHY_LSB +: $bits(phy_addr_t)] = phy_addr;
            rdata[MCR_REG_LSB +: $bits(phy_addr_t)] = reg_addr;
            rdata[MCR_READ_BIT]                     = rd_op;
            rdata[MCR_DIV_LSB +: DIV_W]             = div;
            rdata[MCR_DONE_BIT]                     = done;
            rdata[MCR_BUSY_BIT]                     = busy;
         end
         OFS_MDR:
            rdata[$bits(mdio_data_t)-1:0] = mdr;
         default:
            rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: emac_pkg.sv
// Ethernet MAC configuration package
// Widths, register map, field positions and shared types for the
// APB register block and the MII management engine
`default_nettype none

package emac_pkg;

   //==========================================================
   // Widths and counts
   //==========================================================
   localparam int DATA_W        = 32;
   localparam int ADDR_W        = 12;
   localparam int MAC_W         = 48;
   localparam int IFG_W         = 6;
   localparam int DIV_W         = 8;
   localparam int PREAMBLE_BITS = 32;
   localparam int FRAME_BITS    = 64;
   // Bits the station drives in a read frame (preamble to reg address)
   localparam int HDR_BITS      = 46;

   // Byte address split: group | word offset | byte lane
   localparam int OFS_LSB = 2;
   localparam int OFS_W   = 4;
   localparam int GRP_LSB = OFS_LSB + OFS_W;

   //==========================================================
   // Vector types
   //==========================================================
   typedef logic [DATA_W-1:0]         apb_data_t;
   typedef logic [ADDR_W-1:0]         apb_addr_t;
   typedef logic [MAC_W-1:0]          mac_addr_t;
   typedef logic [4:0]                phy_addr_t;
   typedef logic [15:0]               mdio_data_t;
   typedef logic [DIV_W-1:0]          mdc_div_t;
   typedef logic [1:0]                speed_t;
   typedef logic [OFS_W-1:0]          reg_ofs_t;
   typedef logic [ADDR_W-GRP_LSB-1:0] reg_grp_t;

   //==========================================================
   // Address map
   //==========================================================
   localparam apb_addr_t ADDR_MAC_LO = 12'h080;
   localparam apb_addr_t ADDR_MAC_HI = 12'h084;
   localparam apb_addr_t ADDR_MODE   = 12'h088;
   localparam apb_addr_t ADDR_MCR    = 12'h0C0;
   localparam apb_addr_t ADDR_MDR    = 12'h0C4;

   // Group codes and word offsets derived from the map
   localparam reg_grp_t GRP_CFG    = ADDR_MAC_LO[ADDR_W-1:GRP_LSB];
   localparam reg_grp_t GRP_MIIM   = ADDR_MCR[ADDR_W-1:GRP_LSB];
   localparam reg_ofs_t OFS_MAC_LO = ADDR_MAC_LO[GRP_LSB-1:OFS_LSB];
   localparam reg_ofs_t OFS_MAC_HI = ADDR_MAC_HI[GRP_LSB-1:OFS_LSB];
   localparam reg_ofs_t OFS_MODE   = ADDR_MODE[GRP_LSB-1:OFS_LSB];
   localparam reg_ofs_t OFS_MCR    = ADDR_MCR[GRP_LSB-1:OFS_LSB];
   localparam reg_ofs_t OFS_MDR    = ADDR_MDR[GRP_LSB-1:OFS_LSB];

   // Mode register fields
   localparam int MODE_SPEED_LSB  = 0;
   localparam int MODE_DUPLEX_BIT = 2;
   localparam int MODE_IFG_LSB    = 4;

   // Control register fields
   localparam int MCR_PHY_LSB  = 0;
   localparam int MCR_REG_LSB  = 5;
   localparam int MCR_READ_BIT = 10;
   localparam int MCR_DIV_LSB  = 11;
   localparam int MCR_DONE_BIT = 30;
   localparam int MCR_BUSY_BIT = 31;

   // Reset values
   localparam mac_addr_t          DEFAULT_MAC = 48'h0;
   localparam logic [IFG_W-1:0]   DEFAULT_IFG = 6'd12;
   localparam mdc_div_t           DEFAULT_DIV = 8'd4;

   //==========================================================
   // FSM and bundles
   //==========================================================
   typedef enum logic [1:0] {
      MIIM_IDLE,
      MIIM_SHIFT,
      MIIM_DONE
   } miim_state_t;

   // Link configuration for the datapath, 57 bits
   typedef struct packed {
      mac_addr_t        mac_addr;
      speed_t           speed;
      logic             duplex;
      logic [IFG_W-1:0] ifg;
   } cfg_t;

   // Register access from the APB slave, 38 bits
   typedef struct packed {
      reg_ofs_t  offset;
      logic      wr;
      logic      rd;
      apb_data_t wdata;
   } reg_bus_t;

endpackage

`default_nettype wire

// File: emac_properties.sv
// APB and MDIO properties of the Ethernet MAC configuration block
// Bound to the top level; failures raise $error and bump a counter
`timescale 1ns/1ps
`default_nettype none

module emac_properties
(
   input logic pclk,
   input logic presetn_sync,
   input logic pready,
   input logic mdc,
   input logic mdo_en,
   input logic irq,
   input logic busy
);

   // Failure count, watched by the testbench
   int error_count = 0;

   //============================================================
   // APB
   //============================================================
   // Zero wait states
   ap_pready_high: assert property (@(posedge pclk) disable iff (!presetn_sync) pready)
   else
   begin
      $error("pready low");
      error_count++;
   end

   //============================================================
   // MDIO
   //============================================================
   // Bus enable moves only with busy or right after a falling mdc edge
   ap_mdo_en_edges: assert property (@(posedge pclk) disable iff (!presetn_sync)
                                     $changed(mdo_en) |-> ($changed(busy) || $fell(mdc)))
   else
   begin
      $error("mdo_en changed inside an mdc bit period");
      error_count++;
   end

   // No clock activity between frames
   ap_mdc_quiet: assert property (@(posedge pclk) disable iff (!presetn_sync)
                                  (!busy && $past(!busy)) |-> $stable(mdc))
   else
   begin
      $error("mdc toggled while not busy");
      error_count++;
   end

   // irq only at the end of a frame
   ap_irq_rise: assert property (@(posedge pclk) disable iff (!presetn_sync)
                                 $rose(irq) |-> $fell(busy))
   else
   begin
      $error("irq rose without busy falling");
      error_count++;
   end

endmodule

`default_nettype wire

// File: emac_tb.sv
// Testbench for the Ethernet MAC configuration block
// Drives APB register accesses and MDIO frames against a small PHY model
`timescale 1ns/1ps
`default_nettype none

module emac_tb
   import emac_pkg::*;
();

   localparam int          CLK_PERIOD     = 20;
   localparam int          MDC_DIV        = 2;
   localparam int          TIMEOUT_CYCLES = 4 * (4 * 128 * (MDC_DIV + 1) + 200);
   localparam logic [31:0] SEED           = 32'h21d0_c3a0;

   logic      pclk = 1'b0;
   logic      presetn_sync;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      pready;
   logic      pslverr;
   cfg_t      cfg;
   logic      mdc;
   logic      mdo;
   logic      mdo_en;
   logic      mdi;
   logic      irq;

   // PHY model state, frame bit k lands at position 63-k
   int          rise_count;
   logic [63:0] cap_bits;
   logic [63:0] en_bits;
   time         rise_time [2];
   logic [15:0] phy_data;

   logic [31:0] rng_state;
   cfg_t        exp_cfg;
   int          cycle_count = 0;
   apb_addr_t   bad_addr [4] = '{12'h000, 12'h08C, 12'h0C8, 12'h081};

   emac uut
   (
      .pclk         ( pclk         ),
      .presetn_sync ( presetn_sync ),
      .psel         ( psel         ),
      .penable      ( penable      ),
      .pwrite       ( pwrite       ),
      .paddr        ( paddr        ),
      .pwdata       ( pwdata       ),
      .prdata       ( prdata       ),
      .pready       ( pready       ),
      .pslverr      ( pslverr      ),
      .cfg          ( cfg          ),
      .mdc          ( mdc          ),
      .mdo          ( mdo          ),
      .mdo_en       ( mdo_en       ),
      .mdi          ( mdi          ),
      .irq          ( irq          )
   );

   // APB and MDIO properties on the top level
   bind emac emac_properties u_props
   (
      .pclk         ( pclk         ),
      .presetn_sync ( presetn_sync ),
      .pready       ( pready       ),
      .mdc          ( mdc          ),
      .mdo_en       ( mdo_en       ),
      .irq          ( irq          ),
      .busy         ( u_miim.busy  )
   );

   always #(CLK_PERIOD / 2) pclk = ~pclk;

   //============================================================
   // Helpers
   //============================================================
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Control word: phy 4:0, reg 9:5, read 10, divider 18:11
   function automatic apb_data_t mcr_word(input logic [4:0] phy, input logic [4:0] reg_a,
                                          input logic rd, input logic [7:0] div);
      apb_data_t w;
      w        = '0;
      w[4:0]   = phy;
      w[9:5]   = reg_a;
      w[10]    = rd;
      w[18:11] = div;
      return w;
   endfunction

   task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
      assert (got === exp)
      else
      begin
         $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "value check failed");
      end
   endtask

   // Setup then access phase, called and returning on a falling edge
   task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge pclk);
      penable = 1'b1;
      #(CLK_PERIOD / 4);
      err = pslverr;
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge pclk);
      penable = 1'b1;
      #(CLK_PERIOD / 4);
      data = prdata;
      err  = pslverr;
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_register(input apb_addr_t addr, input apb_data_t exp);
      apb_data_t data;
      logic      err;
      apb_read(addr, data, err);
      check_equal(err, 1'b0, "pslverr on mapped read");
      check_equal(data, exp, "register read-back");
   endtask

   // Poll the busy bit until the frame ends
   task automatic wait_frame_done;
      apb_data_t status;
      logic      err;
      status = '1;
      while (status[31])
         apb_read(ADDR_MCR, status, err);
   endtask

   //============================================================
   // PHY model
   //============================================================
   always @(posedge mdc)
   begin
      if (rise_count < 64)
      begin
         cap_bits[63 - rise_count] = mdo;
         en_bits[63 - rise_count]  = mdo_en;
      end
      if (rise_count < 2)
         rise_time[rise_count] = $time;
      rise_count = rise_count + 1;
   end

   // Data bits of a read go out after the falling mdc edge
   always @(negedge mdc)
   begin
      int k;
      k = rise_count;
      @(negedge pclk);
      if (k >= 48 && k < 64 && cap_bits[29:28] == 2'b10)
         mdi = phy_data[63 - k];
      else
         mdi = 1'b1;
   end

   // Cycle limit and concurrent assertion watch
   always @(posedge pclk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: no completion within %0d cycles", TIMEOUT_CYCLES);
         $display("RESULT: FAIL");
         $fatal(1, "timeout");
      end
      else if (uut.u_props.error_count != 0)
      begin
         $display("A concurrent assertion on APB or MDIO failed");
         $display("RESULT: FAIL");
         $fatal(1, "property failure");
      end
   end

   //============================================================
   // Test sequence
   //============================================================
   initial
   begin
      apb_data_t   r;
      apb_data_t   data;
      apb_data_t   mcr_cmd;
      logic        err;
      logic [15:0] wr_data;
      logic [4:0]  phy;
      logic [4:0]  reg_a;
      logic [63:0] exp_frame;
      rng_state    = SEED;
      presetn_sync = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      mdi          = 1'b1;
      rise_count   = 0;
      cap_bits     = '0;
      en_bits      = '0;
      phy_data     = '0;
      repeat (3) @(negedge pclk);
      presetn_sync = 1'b1;
      @(negedge pclk);

      // Reset state
      check_equal(mdc, 1'b0, "mdc after reset");
      check_equal(mdo_en, 1'b0, "mdo_en after reset");
      check_equal(irq, 1'b0, "irq after reset");
      check_equal(mdo, 1'b1, "mdo after reset");
      exp_cfg = '{mac_addr: DEFAULT_MAC, speed: 2'b00, duplex: 1'b0, ifg: DEFAULT_IFG};
      check_equal(cfg, exp_cfg, "cfg after reset");
      check_register(ADDR_MCR, mcr_word(5'h0, 5'h0, 1'b0, DEFAULT_DIV));

      // Configuration writes, masked read-back and cfg export
      rng_state = xorshift(rng_state);
      r = rng_state;
      apb_write(ADDR_MAC_LO, r, err);
      exp_cfg.mac_addr[31:0] = r;
      check_equal(cfg, exp_cfg, "cfg after MAC low write");
      check_register(ADDR_MAC_LO, r);
      rng_state = xorshift(rng_state);
      r = rng_state;
      apb_write(ADDR_MAC_HI, r, err);
      exp_cfg.mac_addr[47:32] = r[15:0];
      check_equal(cfg, exp_cfg, "cfg after MAC high write");
      check_register(ADDR_MAC_HI, r & 32'h0000_ffff);
      rng_state = xorshift(rng_state);
      r = rng_state;
      apb_write(ADDR_MODE, r, err);
      exp_cfg.speed  = r[1:0];
      exp_cfg.duplex = r[2];
      exp_cfg.ifg    = r[9:4];
      check_equal(cfg, exp_cfg, "cfg after mode write");
      check_register(ADDR_MODE, r & 32'h0000_03f7);

      // Unmapped and misaligned addresses
      for (int i = 0; i < 4; i++)
      begin
         rng_state = xorshift(rng_state);
         apb_write(bad_addr[i], rng_state, err);
         check_equal(err, 1'b1, "pslverr on unmapped write");
         apb_read(bad_addr[i], data, err);
         check_equal(err, 1'b1, "pslverr on unmapped read");
         check_equal(data, 32'h0, "prdata on unmapped read");
      end
      check_equal(cfg, exp_cfg, "cfg after unmapped accesses");
      check_register(ADDR_MAC_LO, exp_cfg.mac_addr[31:0]);
      check_register(ADDR_MAC_HI, {16'h0, exp_cfg.mac_addr[47:32]});
      check_register(ADDR_MODE, {22'h0, exp_cfg.ifg, 1'b0, exp_cfg.duplex, exp_cfg.speed});
      check_register(ADDR_MCR, mcr_word(5'h0, 5'h0, 1'b0, DEFAULT_DIV));
      check_register(ADDR_MDR, 32'h0);

      //============================================================
      // MDIO write frame
      //============================================================
      rng_state = xorshift(rng_state);
      wr_data = rng_state[15:0];
      phy     = rng_state[20:16];
      reg_a   = rng_state[25:21];
      apb_write(ADDR_MDR, {16'h0, wr_data}, err);
      check_register(ADDR_MDR, {16'h0, wr_data});
      mcr_cmd    = mcr_word(phy, reg_a, 1'b0, MDC_DIV);
      rise_count = 0;
      apb_write(ADDR_MCR, mcr_cmd, err);
      // Second command while busy must be dropped
      apb_write(ADDR_MCR, mcr_word(~phy, ~reg_a, 1'b1, 8'd7), err);
      check_register(ADDR_MCR, mcr_cmd | 32'h8000_0000);
      wait_frame_done();
      exp_frame = {32'hffff_ffff, 2'b01, 2'b01, phy, reg_a, 2'b10, wr_data};
      check_equal(rise_count, 64, "mdc periods in write frame");
      check_equal(cap_bits, exp_frame, "write frame bits");
      check_equal(en_bits, {64{1'b1}}, "mdo_en during write frame");
      check_equal(rise_time[1] - rise_time[0], 2 * (MDC_DIV + 1) * CLK_PERIOD, "mdc period");
      check_equal(irq, 1'b1, "irq after write frame");
      check_register(ADDR_MCR, mcr_cmd | 32'h4000_0000);

      //============================================================
      // MDIO read frame
      //============================================================
      rng_state  = xorshift(rng_state);
      phy_data   = rng_state[15:0];
      phy        = rng_state[20:16];
      reg_a      = rng_state[25:21];
      mcr_cmd    = mcr_word(phy, reg_a, 1'b1, MDC_DIV);
      rise_count = 0;
      apb_write(ADDR_MCR, mcr_cmd, err);
      check_equal(irq, 1'b0, "irq cleared by control write");
      wait_frame_done();
      exp_frame = {32'hffff_ffff, 2'b01, 2'b10, phy, reg_a, 18'h0};
      check_equal(cap_bits[63:18], exp_frame[63:18], "read frame header");
      check_equal(en_bits, {{46{1'b1}}, 18'h0}, "mdo_en during read frame");
      check_register(ADDR_MDR, {16'h0, phy_data});
      check_equal(irq, 1'b1, "irq after read frame");
      repeat (10) @(negedge pclk);
      check_equal(irq, 1'b1, "irq held until next control write");

      // Next control write drops irq and runs one more frame
      rise_count = 0;
      apb_write(ADDR_MCR, mcr_word(phy, reg_a, 1'b0, MDC_DIV), err);
      check_equal(irq, 1'b0, "irq after new control write");
      wait_frame_done();
      check_equal(irq, 1'b1, "irq after last frame");

      if (uut.u_props.error_count == 0)
      begin
         $display("RESULT: PASS");
         $finish;
      end
      else
      begin
         $display("Concurrent assertions reported failures");
         $display("RESULT: FAIL");
         $fatal(1, "property failure");
      end
   end

endmodule

`default_nettype wire
